//--- vlog.f
design/bus_pkg.sv
design/isa_pkg.sv
design/mem_req_if.sv
design/wishbone_manager.sv
design/cpu_core.sv
design/team_top.sv
bench/team_top_asserts.sv
bench/tb_team_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; pass only if the output holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_team_top -f vlog.f -o sim_tb_team_top &&
./obj_dir/sim_tb_team_top 2>&1 | tee /dev/stderr | grep -qx ">>> PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- bench/tb_team_top.sv
/*
 * Testbench for the chip top level
 * Random program, Wishbone memory with random ack delay, ISA model and checks
 */
`timescale 1ns/1ps

module tb_team_top;

   localparam int PROG_LEN = 60;
   localparam int TMO      = 2000;

   logic        clk;
   logic        reset_i;
   logic        en_i;
   logic [31:0] dat_i;
   logic        ack_i;
   logic [31:0] adr_o;
   logic [31:0] dat_o;
   logic [3:0]  sel_o;
   logic        we_o;
   logic        stb_o;
   logic        cyc_o;
   logic [33:0] gpio_o;

   int          seed = 32'h79e5_bc96;
   logic [31:0] mem   [256];
   logic [31:0] m_mem [256];
   logic [31:0] m_reg [16];
   // Expected transfers in bus order
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [3:0]  exp_sel  [$];
   logic        exp_we   [$];
   logic [31:0] exp_out  [$];
   // en_i as seen at the last rising edge
   logic        en_h1;

   team_top dut_i (
      .clk     (clk),
      .reset_i (reset_i),
      .en_i    (en_i),
      .dat_i   (dat_i),
      .ack_i   (ack_i),
      .adr_o   (adr_o),
      .dat_o   (dat_o),
      .sel_o   (sel_o),
      .we_o    (we_o),
      .stb_o   (stb_o),
      .cyc_o   (cyc_o),
      .gpio_o  (gpio_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) en_h1 <= en_i;

   function automatic int unsigned rnd(int unsigned n);
      int unsigned r;
      r = $random(seed);
      return r % n;
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic compare(string name, logic [31:0] exp, logic [31:0] got);
      if (exp !== got) begin
         $display("ERR %s exp %h got %h", name, exp, got);
         $display(">>> FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   function automatic logic [31:0] rv(logic [3:0] idx);
      return (idx == 4'd0) ? 32'd0 : m_reg[idx];
   endfunction

   task automatic push_xfer(logic [31:0] a, logic we, logic [3:0] sel, logic [31:0] d,
                            logic [31:0] o);
      exp_addr.push_back(a);
      exp_we.push_back(we);
      exp_sel.push_back(sel);
      exp_data.push_back(d);
      exp_out.push_back(o);
   endtask

   // Random program, every opcode once up front, then random mix, halt last
   task automatic build_program();
      isa_pkg::opcode_e ops [12];
      isa_pkg::opcode_e op;
      logic [3:0]  rd;
      logic [3:0]  rs;
      logic [15:0] imm;
      int unsigned lim;
      ops = '{isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
              isa_pkg::OP_XOR, isa_pkg::OP_ADDI, isa_pkg::OP_LUI, isa_pkg::OP_LW,
              isa_pkg::OP_SW, isa_pkg::OP_SB, isa_pkg::OP_BEQ, isa_pkg::OP_OUT};
      // Fill pattern over the whole address
      for (int a = 0; a < 256; a++) begin
         mem[a] = 32'h5a5a_0000 | (32'(a) * 32'h0000_0103);
      end
      for (int i = 0; i < PROG_LEN - 1; i++) begin
         op  = (i < 12) ? ops[i] : ops[rnd(12)];
         rd  = 4'(rnd(16));
         rs  = 4'(rnd(16));
         imm = 16'(rnd(65536));
         case (op)
            isa_pkg::OP_LW, isa_pkg::OP_SW: begin
               rs  = 4'd0;
               imm = 16'(32'h200 + 4 * rnd(128));
            end
            isa_pkg::OP_SB: begin
               rs  = 4'd0;
               imm = 16'(32'h200 + rnd(512));
            end
            isa_pkg::OP_BEQ: begin
               // Forward only, never past the halt
               lim = (58 - i < 4) ? 58 - i : 4;
               imm = 16'(rnd(lim + 1));
               if (rnd(2) == 0) rs = rd;
            end
            default: ;
         endcase
         mem[i] = {op, rd, rs, 4'(rnd(16)), imm};
      end
      mem[PROG_LEN-1] = {isa_pkg::OP_HALT, 28'd0};
   endtask

   // ISA reference model on its own copy of memory and registers
   task automatic run_model();
      logic [31:0] pc;
      logic [31:0] w;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] rdv;
      logic [31:0] outv;
      logic [3:0]  rd;
      logic [3:0]  rs;
      logic [3:0]  rt;
      logic [3:0]  sel;
      logic        done;
      m_mem = mem;
      for (int r = 0; r < 16; r++) m_reg[r] = 32'd0;
      pc   = 32'd0;
      outv = 32'd0;
      done = 1'b0;
      while (!done) begin
         push_xfer(pc, 1'b0, 4'hf, 32'd0, outv);
         w   = m_mem[pc[9:2]];
         rd  = w[27:24];
         rs  = w[23:20];
         rt  = w[19:16];
         imm = {{16{w[15]}}, w[15:0]};
         ea  = rv(rs) + imm;
         rdv = rv(rd);
         pc  = pc + 32'd4;
         case (isa_pkg::opcode_e'(w[31:28]))
            isa_pkg::OP_ADD:  m_reg[rd] = rv(rs) + rv(rt);
            isa_pkg::OP_SUB:  m_reg[rd] = rv(rs) - rv(rt);
            isa_pkg::OP_AND:  m_reg[rd] = rv(rs) & rv(rt);
            isa_pkg::OP_OR:   m_reg[rd] = rv(rs) | rv(rt);
            isa_pkg::OP_XOR:  m_reg[rd] = rv(rs) ^ rv(rt);
            isa_pkg::OP_ADDI: m_reg[rd] = rv(rs) + imm;
            isa_pkg::OP_LUI:  m_reg[rd] = {w[15:0], 16'd0};
            isa_pkg::OP_LW: begin
               push_xfer({ea[31:2], 2'b00}, 1'b0, 4'hf, 32'd0, outv);
               m_reg[rd] = m_mem[ea[9:2]];
            end
            isa_pkg::OP_SW: begin
               push_xfer({ea[31:2], 2'b00}, 1'b1, 4'hf, rv(rd), outv);
               m_mem[ea[9:2]] = rv(rd);
            end
            isa_pkg::OP_SB: begin
               sel = 4'b0001 << ea[1:0];
               push_xfer(ea, 1'b1, sel, {4{rdv[7:0]}}, outv);
               m_mem[ea[9:2]][8*ea[1:0] +: 8] = rdv[7:0];
            end
            isa_pkg::OP_BEQ:  if (rv(rd) == rv(rs)) pc = pc + (imm << 2);
            isa_pkg::OP_OUT:  outv = rv(rd);
            isa_pkg::OP_HALT: done = 1'b1;
            default: ;
         endcase
      end
   endtask

   // Random enable drops once out of reset
   initial begin
      @(negedge reset_i);
      forever begin
         repeat (1 + rnd(12)) @(posedge clk);
         en_i <= 1'b0;
         repeat (1 + rnd(6)) @(posedge clk);
         en_i <= 1'b1;
      end
   end

   // Wishbone memory serving one cycle, checked against transfer n
   task automatic serve_cycle(int n);
      int          cnt;
      logic [31:0] mask;
      cnt = 0;
      @(negedge clk);
      while (!cyc_o) begin
         @(negedge clk);
         cnt++;
         if (cnt > TMO) abort_run("Timeout waiting for a Wishbone cycle to start");
      end
      mask = {{8{sel_o[3]}}, {8{sel_o[2]}}, {8{sel_o[1]}}, {8{sel_o[0]}}};
      if (n == 0) compare("adr_o first cycle", 32'd0, adr_o);
      compare("adr_o", exp_addr[n], adr_o);
      compare("we_o", 32'(exp_we[n]), 32'(we_o));
      compare("sel_o", 32'(exp_sel[n]), 32'(sel_o));
      if (exp_we[n]) compare("dat_o", exp_data[n] & mask, dat_o & mask);
      compare("gpio_o[31:0]", exp_out[n], gpio_o[31:0]);
      // Running flag up, halted flag down
      compare("gpio_o[33:32]", 32'h1, 32'(gpio_o[33:32]));
      // No bus cycle starts with enable low
      compare("en_i at cycle start", 32'd1, 32'(en_h1));
      // Ack on a rising edge, 0 to 4 cycles after the earliest one
      repeat (1 + rnd(5)) @(posedge clk);
      ack_i <= 1'b1;
      dat_i <= mem[adr_o[9:2]];
      if (we_o) begin
         for (int j = 0; j < 4; j++) begin
            if (sel_o[j]) mem[adr_o[9:2]][8*j +: 8] = dat_o[8*j +: 8];
         end
      end
      @(posedge clk);
      ack_i <= 1'b0;
   endtask

   initial begin
      int cnt;
      reset_i = 1'b1;
      en_i    = 1'b1;
      ack_i   = 1'b0;
      dat_i   = 32'd0;
      build_program();
      run_model();
      repeat (8) @(posedge clk);
      reset_i <= 1'b0;
      @(negedge clk);
      compare("gpio_o", 32'd0, gpio_o[31:0]);
      compare("gpio_o[33:32]", 32'd0, 32'(gpio_o[33:32]));
      compare("cyc_o", 32'd0, 32'(cyc_o));
      for (int n = 0; n < exp_addr.size(); n++) begin
         serve_cycle(n);
      end
      cnt = 0;
      @(negedge clk);
      while (!gpio_o[33]) begin
         @(negedge clk);
         cnt++;
         if (cnt > TMO) abort_run("Timeout waiting for the core to halt");
      end
      compare("gpio_o[32]", 32'd0, 32'(gpio_o[32]));
      // Parked core stays off the bus
      repeat (50) begin
         @(negedge clk);
         compare("cyc_o", 32'd0, 32'(cyc_o));
      end
      for (int a = 128; a < 256; a++) begin
         compare($sformatf("mem[%0h]", a * 4), m_mem[a], mem[a]);
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- bench/team_top_asserts.sv
/*
 * Wishbone protocol and reset checks for the chip top level
 * Bound onto team_top from the testbench
 */
`timescale 1ns/1ps

module team_top_asserts (
   input logic        clk,
   input logic        reset_i,
   input logic        en_i,
   input logic        ack_i,
   input logic [31:0] adr_o,
   input logic [31:0] dat_o,
   input logic [3:0]  sel_o,
   input logic        we_o,
   input logic        stb_o,
   input logic        cyc_o,
   input logic [33:0] gpio_o
);

   // Classic cycle, strobe follows cycle
   a_stb_cyc: assert property (@(posedge clk) disable iff (reset_i) stb_o == cyc_o)
      else $error("stb_o differs from cyc_o");

   // Address phase held until ack
   a_hold: assert property (@(posedge clk) disable iff (reset_i)
      (cyc_o && !ack_i) |=> $stable({adr_o, dat_o, sel_o, we_o}))
      else $error("Wishbone outputs changed before ack");

   // New cycle only after an edge with enable high
   a_en: assert property (@(posedge clk) disable iff (reset_i)
      $rose(cyc_o) |-> $past(en_i))
      else $error("cyc_o rose without en_i high at the previous edge");

   // Quiet outputs while reset is held
   a_reset: assert property (@(posedge clk)
      (reset_i && $past(reset_i)) |-> (!cyc_o && !stb_o && gpio_o == '0))
      else $error("outputs active during reset");

endmodule

bind team_top team_top_asserts asrt_i (
   .clk     (clk),
   .reset_i (reset_i),
   .en_i    (en_i),
   .ack_i   (ack_i),
   .adr_o   (adr_o),
   .dat_o   (dat_o),
   .sel_o   (sel_o),
   .we_o    (we_o),
   .stb_o   (stb_o),
   .cyc_o   (cyc_o),
   .gpio_o  (gpio_o)
);

//--- design/team_top.sv
/*
 * Chip top level
 * Load/store core with its Wishbone manager, bus and GPIO pins
 */
`timescale 1ns/1ps

module team_top (
   input  logic                       clk,
   input  logic                       reset_i,
   // Freezes the core between instructions
   input  logic                       en_i,
   // Wishbone inputs
   input  logic [bus_pkg::DATA_W-1:0] dat_i,
   input  logic                       ack_i,
   // Wishbone outputs
   output logic [bus_pkg::ADDR_W-1:0] adr_o,
   output logic [bus_pkg::DATA_W-1:0] dat_o,
   output logic [bus_pkg::SEL_W-1:0]  sel_o,
   output logic                       we_o,
   output logic                       stb_o,
   output logic                       cyc_o,
   // Output port, running and halted flags
   output logic [33:0]                gpio_o
);

   logic [bus_pkg::DATA_W-1:0] out_port;
   logic                       running;
   logic                       halted;

   // Core to manager link
   mem_req_if mem_link ();

   cpu_core cpu (
      .clk        (clk),
      .reset_i    (reset_i),
      .en_i       (en_i),
      .mem        (mem_link.core),
      .out_port_o (out_port),
      .running_o  (running),
      .halted_o   (halted)
   );

   wishbone_manager wb_mgr (
      .clk     (clk),
      .reset_i (reset_i),
      .bus     (mem_link.manager),
      .dat_i   (dat_i),
      .ack_i   (ack_i),
      .adr_o   (adr_o),
      .dat_o   (dat_o),
      .sel_o   (sel_o),
      .we_o    (we_o),
      .stb_o   (stb_o),
      .cyc_o   (cyc_o)
   );

   // Pin map, halted on top
   assign gpio_o = {halted, running, out_port};

endmodule

//--- design/cpu_core.sv
/*
 * Compact 32-bit load/store processor
 * Sequencer, register file, ALU, branch unit and output port
 * Fetch and data accesses go out through the manager link
 */
`timescale 1ns/1ps

module cpu_core (
   input  logic                       clk,
   input  logic                       reset_i,
   input  logic                       en_i,
   mem_req_if.core                    mem,
   output logic [bus_pkg::DATA_W-1:0] out_port_o,
   output logic                       running_o,
   output logic                       halted_o
);

   // Architectural state
   isa_pkg::core_state_e       state_q;
   logic [bus_pkg::ADDR_W-1:0] pc_q;
   logic [bus_pkg::DATA_W-1:0] instr_q;
   logic [bus_pkg::DATA_W-1:0] regs_q [isa_pkg::NUM_REGS];
   logic [bus_pkg::DATA_W-1:0] out_q;
   logic                       running_q;
   logic                       halted_q;

   // Decode
   isa_pkg::opcode_e           opc;
   logic [isa_pkg::REG_AW-1:0] rd_idx;
   logic [isa_pkg::REG_AW-1:0] rs_idx;
   logic [isa_pkg::REG_AW-1:0] rt_idx;
   logic [bus_pkg::DATA_W-1:0] imm_sext;
   logic [bus_pkg::DATA_W-1:0] rd_val;
   logic [bus_pkg::DATA_W-1:0] rs_val;
   logic [bus_pkg::DATA_W-1:0] rt_val;

   // Execute
   logic [bus_pkg::DATA_W-1:0] alu_res;
   logic                       alu_wr;
   logic [bus_pkg::ADDR_W-1:0] eff_addr;
   logic [bus_pkg::ADDR_W-1:0] pc_next;
   logic                       take_branch;
   logic                       req_take;

   assign opc    = isa_pkg::opcode_e'(instr_q[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB]);
   assign rd_idx = instr_q[isa_pkg::RD_LSB +: isa_pkg::REG_AW];
   assign rs_idx = instr_q[isa_pkg::RS_LSB +: isa_pkg::REG_AW];
   assign rt_idx = instr_q[isa_pkg::RT_LSB +: isa_pkg::REG_AW];

   // Sign-extended immediate
   assign imm_sext = {{(bus_pkg::DATA_W - isa_pkg::IMM_W){instr_q[isa_pkg::IMM_W-1]}},
                      instr_q[isa_pkg::IMM_W-1:0]};

   // Register reads, r0 reads as zero
   assign rd_val = (rd_idx == '0) ? '0 : regs_q[rd_idx];
   assign rs_val = (rs_idx == '0) ? '0 : regs_q[rs_idx];
   assign rt_val = (rt_idx == '0) ? '0 : regs_q[rt_idx];

   // ALU and LUI
   always_comb begin
      alu_wr = 1'b1;
      case (opc)
         isa_pkg::OP_ADD:  alu_res = rs_val + rt_val;
         isa_pkg::OP_SUB:  alu_res = rs_val - rt_val;
         isa_pkg::OP_AND:  alu_res = rs_val & rt_val;
         isa_pkg::OP_OR:   alu_res = rs_val | rt_val;
         isa_pkg::OP_XOR:  alu_res = rs_val ^ rt_val;
         isa_pkg::OP_ADDI: alu_res = rs_val + imm_sext;
         isa_pkg::OP_LUI:  alu_res = imm_sext << isa_pkg::IMM_W;
         default: begin
            alu_res = '0;
            alu_wr  = 1'b0;
         end
      endcase
   end

   // Load/store address is rs plus immediate
   assign eff_addr = rs_val + imm_sext;

   // Branch target is pc plus 4 plus word offset
   assign take_branch = (opc == isa_pkg::OP_BEQ) && (rd_val == rs_val);
   assign pc_next     = take_branch ? pc_q + 32'd4 + (imm_sext << 2) : pc_q + 32'd4;

   // Request drive
   // All fields come from registers that hold until the handshake
   always_comb begin
      mem.req_valid = 1'b0;
      mem.req_addr  = pc_q;
      mem.req_wdata = '0;
      mem.req_sel   = '1;
      mem.req_we    = 1'b0;
      case (state_q)
         isa_pkg::ST_FETCH: begin
            // Enable low holds off any new bus cycle
            mem.req_valid = en_i;
         end
         isa_pkg::ST_MEM: begin
            mem.req_valid = en_i;
            if (opc == isa_pkg::OP_SB) begin
               // Byte lane picked by the low address bits
               mem.req_addr  = eff_addr;
               mem.req_sel   = {{(bus_pkg::SEL_W-1){1'b0}}, 1'b1} << eff_addr[1:0];
               mem.req_wdata = {bus_pkg::SEL_W{rd_val[7:0]}};
               mem.req_we    = 1'b1;
            end else begin
               // Word access, low bits dropped
               mem.req_addr  = {eff_addr[bus_pkg::ADDR_W-1:2], 2'b00};
               mem.req_wdata = rd_val;
               mem.req_we    = (opc == isa_pkg::OP_SW);
            end
         end
         default: begin
            mem.req_valid = 1'b0;
         end
      endcase
   end

   assign req_take = mem.req_valid && mem.req_ready;

   // Sequencer and register writes
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q   <= isa_pkg::ST_FETCH;
         pc_q      <= '0;
         out_q     <= '0;
         running_q <= 1'b0;
         halted_q  <= 1'b0;
         for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         running_q <= (state_q != isa_pkg::ST_HALT);
         case (state_q)
            isa_pkg::ST_FETCH: begin
               if (req_take) begin
                  state_q <= isa_pkg::ST_FETCH_WAIT;
               end
            end
            isa_pkg::ST_FETCH_WAIT: begin
               if (mem.rsp_valid) begin
                  state_q <= isa_pkg::ST_EXEC;
               end
            end
            isa_pkg::ST_EXEC: begin
               if (alu_wr) begin
                  regs_q[rd_idx] <= alu_res;
               end
               if (opc != isa_pkg::OP_HALT) begin
                  pc_q <= pc_next;
               end
               case (opc)
                  isa_pkg::OP_LW, isa_pkg::OP_SW, isa_pkg::OP_SB: begin
                     state_q <= isa_pkg::ST_MEM;
                  end
                  isa_pkg::OP_OUT: begin
                     out_q   <= rd_val;
                     state_q <= isa_pkg::ST_FETCH;
                  end
                  isa_pkg::OP_HALT: begin
                     // Parked until reset
                     state_q   <= isa_pkg::ST_HALT;
                     running_q <= 1'b0;
                     halted_q  <= 1'b1;
                  end
                  default: begin
                     state_q <= isa_pkg::ST_FETCH;
                  end
               endcase
            end
            isa_pkg::ST_MEM: begin
               if (req_take) begin
                  state_q <= isa_pkg::ST_MEM_WAIT;
               end
            end
            isa_pkg::ST_MEM_WAIT: begin
               if (mem.rsp_valid) begin
                  // Load result lands with the response
                  if (opc == isa_pkg::OP_LW) begin
                     regs_q[rd_idx] <= mem.rsp_rdata;
                  end
                  state_q <= isa_pkg::ST_FETCH;
               end
            end
            default: begin
               state_q <= isa_pkg::ST_HALT;
            end
         endcase
      end
   end

   // Instruction register
   always_ff @(posedge clk) begin
      if ((state_q == isa_pkg::ST_FETCH_WAIT) && mem.rsp_valid) begin
         instr_q <= mem.rsp_rdata;
      end
   end

   assign out_port_o = out_q;
   assign running_o  = running_q;
   assign halted_o   = halted_q;

endmodule

//--- design/wishbone_manager.sv
/*
 * Wishbone classic bus manager
 * Turns one accepted core request into one CYC/STB cycle and
 * returns the read data with a single response pulse
 */
`timescale 1ns/1ps

module wishbone_manager (
   input  logic                       clk,
   input  logic                       reset_i,
   mem_req_if.manager                 bus,
   // Wishbone inputs
   input  logic [bus_pkg::DATA_W-1:0] dat_i,
   input  logic                       ack_i,
   // Wishbone outputs
   output logic [bus_pkg::ADDR_W-1:0] adr_o,
   output logic [bus_pkg::DATA_W-1:0] dat_o,
   output logic [bus_pkg::SEL_W-1:0]  sel_o,
   output logic                       we_o,
   output logic                       stb_o,
   output logic                       cyc_o
);

   bus_pkg::mgr_state_e        state_q;
   logic [bus_pkg::DATA_W-1:0] rdata_q;
   logic                       req_take;

   // Handshake with the core
   // Only one transfer in flight so ready only when idle
   assign bus.req_ready = (state_q == bus_pkg::MS_IDLE);
   assign req_take      = bus.req_valid && bus.req_ready;

   // Response pulse lasts the single MS_RESP cycle
   assign bus.rsp_valid = (state_q == bus_pkg::MS_RESP);
   assign bus.rsp_rdata = rdata_q;

   // Strobe and cycle rise and fall together
   assign cyc_o = (state_q == bus_pkg::MS_BUS);
   assign stb_o = (state_q == bus_pkg::MS_BUS);

   // Controller
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= bus_pkg::MS_IDLE;
         we_o    <= 1'b0;
      end else begin
         case (state_q)
            bus_pkg::MS_IDLE: begin
               if (req_take) begin
                  we_o    <= bus.req_we;
                  state_q <= bus_pkg::MS_BUS;
               end
            end
            bus_pkg::MS_BUS: begin
               // Late ack just stretches the cycle
               if (ack_i) begin
                  we_o    <= 1'b0;
                  state_q <= bus_pkg::MS_RESP;
               end
            end
            bus_pkg::MS_RESP: begin
               state_q <= bus_pkg::MS_IDLE;
            end
            default: begin
               state_q <= bus_pkg::MS_IDLE;
            end
         endcase
      end
   end

   // Address phase registers
   // Loaded on the accepting edge, steady for the whole cycle
   always_ff @(posedge clk) begin
      if (req_take) begin
         adr_o <= bus.req_addr;
         dat_o <= bus.req_wdata;
         sel_o <= bus.req_sel;
      end
   end

   // Read data captured at the acknowledging edge
   always_ff @(posedge clk) begin
      if ((state_q == bus_pkg::MS_BUS) && ack_i) begin
         rdata_q <= dat_i;
      end
   end

endmodule

//--- design/mem_req_if.sv
/*
 * Request and response link between the core and the Wishbone manager
 * Valid/ready request, one-cycle response pulse with read data
 */
`timescale 1ns/1ps

interface mem_req_if;

   // Request side, held by the core until taken
   logic                       req_valid;
   logic                       req_ready;
   logic [bus_pkg::ADDR_W-1:0] req_addr;
   logic [bus_pkg::DATA_W-1:0] req_wdata;
   logic [bus_pkg::SEL_W-1:0]  req_sel;
   logic                       req_we;

   // Response side, no ready since the core always waits
   logic                       rsp_valid;
   logic [bus_pkg::DATA_W-1:0] rsp_rdata;

   modport core (
      output req_valid, req_addr, req_wdata, req_sel, req_we,
      input  req_ready, rsp_valid, rsp_rdata
   );

   modport manager (
      input  req_valid, req_addr, req_wdata, req_sel, req_we,
      output req_ready, rsp_valid, rsp_rdata
   );

endinterface

//--- design/isa_pkg.sv
/*
 * Instruction set of the compact 32-bit load/store core
 * Opcodes, instruction field layout, register count and sequencer states
 */
package isa_pkg;

   // Major opcode in the top nibble
   // Codes not listed here execute as a nop
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_LUI  = 4'h6,
      OP_LW   = 4'h7,
      OP_SW   = 4'h8,
      OP_SB   = 4'h9,
      OP_BEQ  = 4'hA,
      OP_OUT  = 4'hB,
      OP_HALT = 4'hF
   } opcode_e;

   // Instruction field positions
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 28;
   // Destination, or data source for stores
   localparam int RD_LSB  = 24;
   localparam int RS_LSB  = 20;
   localparam int RT_LSB  = 16;
   // Immediate sits in the low bits and is sign-extended
   localparam int IMM_W   = 16;

   // Register file, r0 hardwired to zero on read
   localparam int NUM_REGS = 16;
   localparam int REG_AW   = $clog2(NUM_REGS);

   // Core sequencer
   typedef enum logic [2:0] {
      ST_FETCH,
      ST_FETCH_WAIT,
      ST_EXEC,
      ST_MEM,
      ST_MEM_WAIT,
      ST_HALT
   } core_state_e;

endpackage

//--- design/bus_pkg.sv
/*
 * Bus definitions shared by the core, the Wishbone manager and the top level
 * Widths of address, data and byte select, plus manager states
 */
package bus_pkg;

   // Wishbone and core request widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   // One select bit per byte lane
   localparam int SEL_W  = DATA_W / 8;

   // Wishbone manager controller
   // Idle waits for a request
   // Bus holds the classic cycle open until ack
   // Resp pulses the response back to the core
   typedef enum logic [1:0] {
      MS_IDLE,
      MS_BUS,
      MS_RESP
   } mgr_state_e;

endpackage
